// File: verilog/pll_ctrl_pkg.sv
`default_nettype none

package pll_ctrl_pkg;

    // ========================================
    // register map, word addresses
    // ========================================
    typedef enum logic [3:0] {
        CTRL    = 4'd0,
        DIVIN   = 4'd1,
        DIVFB   = 4'd2,
        STATUS  = 4'd3,
        DIVOUT0 = 4'd4,
        DIVOUT1 = 4'd5,
        DIVOUT2 = 4'd6,
        DIVOUT3 = 4'd7,
        FREQ0   = 4'd8,
        FREQ1   = 4'd9,
        FREQ2   = 4'd10,
        FREQ3   = 4'd11
    } reg_addr_e;

    typedef enum logic [2:0] {IDLE, CHECK, RST, WAIT_LOCK, MEASURE, DONE, ERROR} seq_state_e;

    // fixed widths of the hard macro
    localparam int FM_NOUT    = 8;
    localparam int FM_DIVINW  = 8;
    localparam int FM_DIVFBW  = 16;
    localparam int FM_DIVOUTW = 8;

    // timing, in clk cycles
    localparam int RST_CYCLES   = 4;    // pll reset pulse
    localparam int LOCK_CYCLES  = 64;   // reset release to freqlock
    localparam int LOCK_TIMEOUT = 256;  // sequencer gives up after this
    localparam int MEAS_WINDOW  = 1024; // tick counting window

    localparam int CNT_W   = 16;
    localparam int VCO_MIN = 2;  // divfb/divin lower bound
    localparam int VCO_MAX = 32; // divfb/divin upper bound

endpackage

`default_nettype wire

// File: verilog/pll_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pll_wb_regs #(
    parameter int NOUT    = 4,
    parameter int DIVINW  = 8,
    parameter int DIVFBW  = 16,
    parameter int DIVOUTW = 8
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [3:0]                          wb_adr,
    input  logic [31:0]                         wb_dat_w,
    output logic [31:0]                         wb_dat_r,
    output logic                                wb_ack,
    input  logic                                busy,
    input  logic                                error,
    input  logic                                done,
    input  logic                                freqlock,
    input  logic [NOUT*pll_ctrl_pkg::CNT_W-1:0] counts,
    output logic                                start,
    output logic [DIVINW-1:0]                   divin,
    output logic [DIVFBW-1:0]                   divfb,
    output logic [NOUT*DIVOUTW-1:0]             divout,
    output logic [NOUT-1:0]                     clken,
    output logic                                bypass,
    output logic                                clksel
);
    import pll_ctrl_pkg::*;

    reg_addr_e   addr;
    logic        req;
    logic        acc_en;   // first cycle of a request
    logic [31:0] rd_data;

    assign addr   = reg_addr_e'(wb_adr);
    assign req    = wb_cyc && wb_stb;
    assign acc_en = req && !wb_ack;

    // ========================================
    // read mux
    // ========================================
    always_comb begin
        rd_data = '0;
        case (addr)
            CTRL: begin
                rd_data[1]        = bypass;
                rd_data[2]        = clksel;
                rd_data[8 +: NOUT] = clken;  // apply reads back as 0
            end
            DIVIN:  rd_data[DIVINW-1:0] = divin;
            DIVFB:  rd_data[DIVFBW-1:0] = divfb;
            STATUS: rd_data[3:0] = {done, error, freqlock, busy};
            DIVOUT0, DIVOUT1, DIVOUT2, DIVOUT3: begin
                if (wb_adr[1:0] < NOUT)
                    rd_data[DIVOUTW-1:0] = divout[wb_adr[1:0]*DIVOUTW +: DIVOUTW];
            end
            FREQ0, FREQ1, FREQ2, FREQ3: begin
                if (wb_adr[1:0] < NOUT)
                    rd_data[CNT_W-1:0] = counts[wb_adr[1:0]*CNT_W +: CNT_W];
            end
            default: ;
        endcase
    end

    // ========================================
    // ack, config registers, apply
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
            divin  <= '0;
            divfb  <= '0;
            divout <= '0;
            clken  <= '0;
            bypass <= 1'b0;
            clksel <= 1'b0;
        end else begin
            wb_ack <= acc_en;  // single cycle, no wait states
            start  <= 1'b0;
            if (acc_en && wb_we) begin
                case (addr)
                    CTRL: begin
                        if (!busy) begin  // whole ctrl write dropped while busy
                            start  <= wb_dat_w[0];
                            bypass <= wb_dat_w[1];
                            clksel <= wb_dat_w[2];
                            clken  <= wb_dat_w[8 +: NOUT];
                        end
                    end
                    DIVIN: divin <= wb_dat_w[DIVINW-1:0];
                    DIVFB: divfb <= wb_dat_w[DIVFBW-1:0];
                    DIVOUT0, DIVOUT1, DIVOUT2, DIVOUT3: begin
                        if (wb_adr[1:0] < NOUT)
                            divout[wb_adr[1:0]*DIVOUTW +: DIVOUTW] <= wb_dat_w[DIVOUTW-1:0];
                    end
                    default: ;  // status and freq are read only
                endcase
            end
        end
    end

    // read data only needs to be valid under ack
    always_ff @(posedge clk) begin
        if (acc_en)
            wb_dat_r <= rd_data;
    end

    // master holds the request until it sees ack
    assert property (@(posedge clk) disable iff (reset) wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

// File: verilog/pll_seq.sv
`timescale 1ns/1ps
`default_nettype none

module pll_seq #(
    parameter int NOUT    = 4,
    parameter int DIVINW  = 8,
    parameter int DIVFBW  = 16,
    parameter int DIVOUTW = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic [DIVINW-1:0]       divin,
    input  logic [DIVFBW-1:0]       divfb,
    input  logic [NOUT*DIVOUTW-1:0] divout,
    input  logic [NOUT-1:0]         clken,
    input  logic                    freqlock,
    input  logic                    meas_done,
    output logic                    busy,
    output logic                    error,
    output logic                    done,
    output logic                    load,
    output logic                    pll_reset,
    output logic                    pll_en,
    output logic                    meas_start
);
    import pll_ctrl_pkg::*;

    localparam int CNT_BITS = $clog2(LOCK_TIMEOUT);

    seq_state_e          state;
    logic [CNT_BITS-1:0] cnt;     // reset pulse and lock timeout share it
    logic                cfg_ok;

    // zero dividers are illegal, disabled outputs don't care
    always_comb begin
        cfg_ok = (divin != '0) && (divfb != '0);
        for (int i = 0; i < NOUT; i++) begin
            if (clken[i] && divout[i*DIVOUTW +: DIVOUTW] == '0)
                cfg_ok = 1'b0;
        end
    end

    assign busy  = state inside {CHECK, RST, WAIT_LOCK, MEASURE};
    assign done  = (state == DONE);
    assign error = (state == ERROR);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            cnt        <= '0;
            load       <= 1'b0;
            pll_reset  <= 1'b1;  // pll held in reset until first apply
            pll_en     <= 1'b0;
            meas_start <= 1'b0;
        end else begin
            load       <= 1'b0;
            meas_start <= 1'b0;
            case (state)
                IDLE, DONE, ERROR: if (start) state <= CHECK;
                CHECK: begin
                    cnt       <= '0;
                    pll_reset <= 1'b1;
                    if (cfg_ok) begin
                        load  <= 1'b1;  // wrapper stages config
                        state <= RST;
                    end else begin
                        pll_en <= 1'b0;
                        state  <= ERROR;
                    end
                end
                RST: begin
                    pll_en <= 1'b1;  // staged values valid from here on
                    cnt    <= cnt + 1'b1;
                    if (cnt == CNT_BITS'(RST_CYCLES - 1)) begin
                        pll_reset <= 1'b0;
                        cnt       <= '0;
                        state     <= WAIT_LOCK;
                    end
                end
                WAIT_LOCK: begin
                    cnt <= cnt + 1'b1;
                    if (freqlock) begin
                        meas_start <= 1'b1;
                        state      <= MEASURE;
                    end else if (cnt == CNT_BITS'(LOCK_TIMEOUT - 1)) begin
                        pll_en    <= 1'b0;  // shut down on timeout
                        pll_reset <= 1'b1;
                        state     <= ERROR;
                    end
                end
                MEASURE: if (meas_done) state <= DONE;
                default: state <= IDLE;
            endcase
        end
    end

    // meter done only answers the kick given on measure entry
    assert property (@(posedge clk) disable iff (reset) meas_done |-> state == MEASURE);

endmodule

`default_nettype wire

// File: verilog/pll_wrap.sv
`timescale 1ns/1ps
`default_nettype none

module pll_wrap #(
    parameter int NOUT    = 4,
    parameter int DIVINW  = 8,
    parameter int DIVFBW  = 16,
    parameter int DIVOUTW = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load,
    input  logic [DIVINW-1:0]       divin,
    input  logic [DIVFBW-1:0]       divfb,
    input  logic [NOUT*DIVOUTW-1:0] divout,
    input  logic [NOUT-1:0]         clken,
    input  logic                    bypass,
    input  logic                    clksel,
    output logic [pll_ctrl_pkg::FM_DIVINW-1:0]                     m_divin,
    output logic [pll_ctrl_pkg::FM_DIVFBW-1:0]                     m_divfb,
    output logic [pll_ctrl_pkg::FM_NOUT*pll_ctrl_pkg::FM_DIVOUTW-1:0] m_divout,
    output logic [pll_ctrl_pkg::FM_NOUT-1:0]                       m_clken,
    output logic                                                   m_bypass,
    output logic                                                   m_clksel
);
    import pll_ctrl_pkg::*;

    // ========================================
    // width adaptation to the macro
    // ========================================
    logic [FM_DIVINW-1:0]          w_divin;
    logic [FM_DIVFBW-1:0]          w_divfb;
    logic [FM_NOUT*FM_DIVOUTW-1:0] w_divout;
    logic [FM_NOUT-1:0]            w_clken;

    assign w_divin = FM_DIVINW'(divin);  // zero pad or truncate
    assign w_divfb = FM_DIVFBW'(divfb);

    // divout adapted per field so the lanes stay aligned
    for (genvar i = 0; i < FM_NOUT; i++) begin : g_out
        if (i < NOUT) begin : g_used
            assign w_divout[i*FM_DIVOUTW +: FM_DIVOUTW] = FM_DIVOUTW'(divout[i*DIVOUTW +: DIVOUTW]);
            assign w_clken[i] = clken[i];
        end else begin : g_unused
            assign w_divout[i*FM_DIVOUTW +: FM_DIVOUTW] = '0;  // spare macro outputs off
            assign w_clken[i] = 1'b0;
        end
    end

    // macro only sees new values on an apply
    always_ff @(posedge clk) begin
        if (reset) begin
            m_divin  <= '0;
            m_divfb  <= '0;
            m_divout <= '0;
            m_clken  <= '0;
            m_bypass <= 1'b0;
            m_clksel <= 1'b0;
        end else if (load) begin
            m_divin  <= w_divin;
            m_divfb  <= w_divfb;
            m_divout <= w_divout;
            m_clken  <= w_clken;
            m_bypass <= bypass;
            m_clksel <= clksel;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pll_macro_model.sv
`timescale 1ns/1ps
`default_nettype none

module pll_macro_model (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic                                                   pll_reset,
    input  logic                                                   pll_en,
    input  logic [pll_ctrl_pkg::FM_DIVINW-1:0]                     m_divin,
    input  logic [pll_ctrl_pkg::FM_DIVFBW-1:0]                     m_divfb,
    input  logic [pll_ctrl_pkg::FM_NOUT*pll_ctrl_pkg::FM_DIVOUTW-1:0] m_divout,
    input  logic [pll_ctrl_pkg::FM_NOUT-1:0]                       m_clken,
    input  logic                                                   m_bypass,
    input  logic                                                   m_clksel,
    output logic                                                   freqlock,
    output logic [pll_ctrl_pkg::FM_NOUT-1:0]                       tick
);
    import pll_ctrl_pkg::*;

    localparam int LOCK_BITS = $clog2(LOCK_CYCLES);

    logic [31:0]          vco_lo;
    logic [31:0]          vco_hi;
    logic                 vco_ok;
    logic                 run;
    logic                 lock_q;
    logic [LOCK_BITS-1:0] lock_cnt;
    logic [FM_DIVFBW-1:0] inc;     // per-cycle phase step

    // ========================================
    // lock detect
    // ========================================
    assign vco_lo = VCO_MIN * m_divin;
    assign vco_hi = VCO_MAX * m_divin;
    assign vco_ok = (m_divfb >= vco_lo) && (m_divfb <= vco_hi);

    always_ff @(posedge clk) begin
        if (reset || pll_reset || !pll_en || !vco_ok) begin
            lock_cnt <= '0;
            lock_q   <= 1'b0;
        end else if (!lock_q) begin
            lock_cnt <= lock_cnt + 1'b1;
            if (lock_cnt == LOCK_BITS'(LOCK_CYCLES - 1))
                lock_q <= 1'b1;
        end
    end

    assign freqlock = lock_q && !pll_reset;  // lock lost as soon as reset hits

    // ========================================
    // output tick generators
    // ========================================
    assign inc = m_bypass ? FM_DIVFBW'(m_divin) : m_divfb;  // bypass passes reference
    assign run = pll_en && !pll_reset && (freqlock || m_bypass);

    for (genvar i = 0; i < FM_NOUT; i++) begin : g_acc
        logic [31:0] acc;
        logic [31:0] thr;
        logic [31:0] sum;
        logic        tick_q;

        assign thr = m_divin * m_divout[i*FM_DIVOUTW +: FM_DIVOUTW];  // divin*divout
        assign sum = acc + inc;

        always_ff @(posedge clk) begin
            if (reset || !run || !m_clken[i]) begin
                acc    <= '0;
                tick_q <= 1'b0;
            end else if (sum >= thr) begin
                acc    <= sum - thr;  // wrap, one tick
                tick_q <= 1'b1;
            end else begin
                acc    <= sum;
                tick_q <= 1'b0;
            end
        end

        assign tick[i] = tick_q;
    end

    assert property (@(posedge clk) disable iff (reset) pll_en |-> m_divin != '0);

    // ref select and dividers only move while unlocked, i.e. under pll reset
    assert property (@(posedge clk) disable iff (reset)
        $changed({m_clksel, m_divin, m_divfb}) |-> !freqlock);

endmodule

`default_nettype wire

// File: verilog/pll_freq_meter.sv
`timescale 1ns/1ps
`default_nettype none

module pll_freq_meter #(
    parameter int NOUT = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                meas_start,
    input  logic [NOUT-1:0]                     tick,
    output logic                                meas_done,
    output logic [NOUT*pll_ctrl_pkg::CNT_W-1:0] counts
);
    import pll_ctrl_pkg::*;

    localparam int WIN_BITS = $clog2(MEAS_WINDOW);

    logic                active;   // window open
    logic [WIN_BITS-1:0] win_cnt;

    // window of MEAS_WINDOW cycles, done one cycle after it closes
    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            win_cnt   <= '0;
            meas_done <= 1'b0;
        end else begin
            meas_done <= 1'b0;
            if (meas_start) begin
                active  <= 1'b1;
                win_cnt <= '0;
            end else if (active) begin
                win_cnt <= win_cnt + 1'b1;
                if (win_cnt == WIN_BITS'(MEAS_WINDOW - 1)) begin
                    active    <= 1'b0;
                    meas_done <= 1'b1;
                end
            end
        end
    end

    // per-output tick counters, held after the window
    for (genvar i = 0; i < NOUT; i++) begin : g_cnt
        logic [CNT_W-1:0] cnt_q;

        always_ff @(posedge clk) begin
            if (reset || meas_start)
                cnt_q <= '0;
            else if (active && tick[i])
                cnt_q <= cnt_q + 1'b1;
        end

        assign counts[i*CNT_W +: CNT_W] = cnt_q;
    end

endmodule

`default_nettype wire

// File: verilog/pll_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module pll_ctrl_top #(
    parameter int NOUT    = 4,   // 1 to 8
    parameter int DIVINW  = 8,
    parameter int DIVFBW  = 16,
    parameter int DIVOUTW = 8
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic            wb_we,
    input  logic [3:0]      wb_adr,
    input  logic [31:0]     wb_dat_w,
    output logic [31:0]     wb_dat_r,
    output logic            wb_ack,
    output logic            freqlock,
    output logic [NOUT-1:0] ticks
);
    import pll_ctrl_pkg::*;

    // ========================================
    // stage wires
    // ========================================
    logic                    start, busy, error, done;
    logic [DIVINW-1:0]       divin;
    logic [DIVFBW-1:0]       divfb;
    logic [NOUT*DIVOUTW-1:0] divout;
    logic [NOUT-1:0]         clken;
    logic                    bypass, clksel;
    logic                    load, pll_reset, pll_en;
    logic                    meas_start, meas_done;
    logic [NOUT*CNT_W-1:0]   counts;

    logic [FM_DIVINW-1:0]          m_divin;
    logic [FM_DIVFBW-1:0]          m_divfb;
    logic [FM_NOUT*FM_DIVOUTW-1:0] m_divout;
    logic [FM_NOUT-1:0]            m_clken;
    logic                          m_bypass, m_clksel;
    logic [FM_NOUT-1:0]            m_tick;   // full macro width

    assign ticks = m_tick[NOUT-1:0];  // unused macro outputs dropped

    pll_wb_regs #(.NOUT(NOUT), .DIVINW(DIVINW), .DIVFBW(DIVFBW), .DIVOUTW(DIVOUTW)) u_regs (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .busy, .error, .done, .freqlock, .counts,
        .start, .divin, .divfb, .divout, .clken, .bypass, .clksel
    );

    pll_seq #(.NOUT(NOUT), .DIVINW(DIVINW), .DIVFBW(DIVFBW), .DIVOUTW(DIVOUTW)) u_seq (
        .clk, .reset, .start, .divin, .divfb, .divout, .clken, .freqlock, .meas_done,
        .busy, .error, .done, .load, .pll_reset, .pll_en, .meas_start
    );

    pll_wrap #(.NOUT(NOUT), .DIVINW(DIVINW), .DIVFBW(DIVFBW), .DIVOUTW(DIVOUTW)) u_wrap (
        .clk, .reset, .load, .divin, .divfb, .divout, .clken, .bypass, .clksel,
        .m_divin, .m_divfb, .m_divout, .m_clken, .m_bypass, .m_clksel
    );

    pll_macro_model u_pll (
        .clk, .reset, .pll_reset, .pll_en,
        .m_divin, .m_divfb, .m_divout, .m_clken, .m_bypass, .m_clksel,
        .freqlock, .tick (m_tick)
    );

    pll_freq_meter #(.NOUT(NOUT)) u_meter (
        .clk, .reset, .meas_start, .tick (ticks), .meas_done, .counts
    );

endmodule

`default_nettype wire

// File: dv/pll_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pll_ctrl_tb;
    import pll_ctrl_pkg::*;

    localparam int NOUT           = 4;
    localparam int MAX_TESTS      = 40;  // apply sequences budgeted
    localparam int TIMEOUT_CYCLES = MAX_TESTS * (LOCK_TIMEOUT + MEAS_WINDOW + 50);

    logic            clk;
    logic            reset;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    logic [3:0]      wb_adr;
    logic [31:0]     wb_dat_w;
    logic [31:0]     wb_dat_r;
    logic            wb_ack;
    logic            freqlock;
    logic [NOUT-1:0] ticks;

    // configuration currently programmed, used by the model
    logic [7:0]      cfg_divin;
    logic [15:0]     cfg_divfb;
    logic [7:0]      cfg_divout [NOUT];
    logic [NOUT-1:0] cfg_clken;
    logic            cfg_bypass;
    logic            cfg_clksel;

    logic [31:0] lfsr;
    int          cycles = 0;

    pll_ctrl_top #(.NOUT(NOUT), .DIVINW(8), .DIVFBW(16), .DIVOUTW(8)) u_pll_ctrl_top (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .freqlock, .ticks
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("ERROR: run still going after %0d clock cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ========================================
    // helpers
    // ========================================
    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // one classic cycle, request held until ack
    task automatic access_bus(input logic we, input reg_addr_e addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= addr;
        wb_dat_w <= wdata;
        do begin
            @(negedge clk);  // sample away from the edge
            waited++;
            if (waited > 4) begin
                $display("ERROR: no wb_ack for %s access at %0t", addr.name(), $time);
                abort_run();
            end
        end while (!wb_ack);
        rdata = wb_dat_r;
        if (waited != 2) begin
            $display("ERROR: wb_ack for %s came %0d cycles after the request, not 1",
                     addr.name(), waited - 1);
            abort_run();
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        if (wb_ack) begin  // ack lasts one cycle only
            $display("ERROR: wb_ack for %s stayed high for more than one cycle at %0t",
                     addr.name(), $time);
            abort_run();
        end
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
        logic [31:0] unused;
        access_bus(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
        access_bus(1'b0, addr, 32'h0, data);
    endtask

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t STATUS got busy=%b lock=%b error=%b done=%b %s",
                     $time, got[0], got[1], got[2], got[3],
                     $sformatf("expected busy=%b lock=%b error=%b done=%b",
                               exp[0], exp[1], exp[2], exp[3]));
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                               input logic [CNT_W-1:0] exp);
        if (int'(got) > int'(exp) + 1 || int'(got) + 1 < int'(exp)) begin  // +-1 window phase
            $display("FAIL time=%0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // ========================================
    // model and sequences
    // ========================================
    function automatic logic [3:0] status_word(input logic busy, input logic lock,
                                               input logic error, input logic done);
        return {done, error, lock, busy};
    endfunction

    function automatic logic [CNT_W-1:0] model_count(input int idx);
        int n;
        if (!cfg_clken[idx])
            return '0;
        if (cfg_bypass)
            n = MEAS_WINDOW / int'(cfg_divout[idx]);
        else
            n = (MEAS_WINDOW * int'(cfg_divfb)) / (int'(cfg_divin) * int'(cfg_divout[idx]));
        if (n > MEAS_WINDOW)
            n = MEAS_WINDOW;  // a strobe fires at most once per cycle
        return CNT_W'(n);
    endfunction

    task automatic draw_legal();
        int range;
        cfg_divin = 8'(1 + rand_bits(4) % 15);
        range     = (VCO_MAX - VCO_MIN) * int'(cfg_divin) + 1;
        cfg_divfb = 16'(VCO_MIN * int'(cfg_divin) + rand_bits(16) % range);
        for (int i = 0; i < NOUT; i++)
            cfg_divout[i] = 8'(1 + rand_bits(4) % 15);
        cfg_clken  = NOUT'(rand_bits(NOUT));
        cfg_bypass = 1'b0;
        cfg_clksel = 1'(rand_bits(1));
    endtask

    task automatic apply_config();
        write_reg(DIVIN, 32'(cfg_divin));
        write_reg(DIVFB, 32'(cfg_divfb));
        for (int i = 0; i < NOUT; i++)
            write_reg(reg_addr_e'(DIVOUT0 + i), 32'(cfg_divout[i]));
        write_reg(CTRL, {20'h0, 4'(cfg_clken), 5'h0, cfg_clksel, cfg_bypass, 1'b1});
    endtask

    task automatic wait_idle(output logic [3:0] st);
        logic [31:0] rd;
        do
            read_reg(STATUS, rd);
        while (rd[0]);
        st = rd[3:0];
    endtask

    task automatic check_freqs();
        logic [31:0] rd;
        for (int i = 0; i < NOUT; i++) begin
            read_reg(reg_addr_e'(FREQ0 + i), rd);
            check_count($sformatf("FREQ%0d", i), rd[CNT_W-1:0], model_count(i));
        end
    endtask

    // tick pins watched over one window, lock pin held the whole time
    task automatic check_tick_pins();
        int n [NOUT];
        for (int i = 0; i < NOUT; i++)
            n[i] = 0;
        repeat (MEAS_WINDOW) begin
            @(negedge clk);
            check_flag("freqlock", freqlock, 1'b1);
            for (int i = 0; i < NOUT; i++) begin
                if (ticks[i])
                    n[i]++;
            end
        end
        for (int i = 0; i < NOUT; i++)
            check_count($sformatf("ticks[%0d]", i), CNT_W'(n[i]), model_count(i));
    endtask

    // ========================================
    // stimulus
    // ========================================
    initial begin
        logic [31:0] val;
        logic [31:0] rd;
        logic [3:0]  st;
        clk        = 1'b0;
        lfsr       = 32'h9876;
        cfg_bypass = 1'b0;
        reset    <= 1'b1;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        read_reg(STATUS, rd);
        check_status(rd[3:0], status_word(1'b0, 1'b0, 1'b0, 1'b0));

        // register write and readback
        for (int r = 0; r < 8; r++) begin
            val = rand_bits(32);
            write_reg(DIVIN, val);
            read_reg(DIVIN, rd);
            check_word("DIVIN", rd, val & 32'h0000_00ff);
            val = rand_bits(32);
            write_reg(DIVFB, val);
            read_reg(DIVFB, rd);
            check_word("DIVFB", rd, val & 32'h0000_ffff);
            for (int i = 0; i < NOUT; i++) begin
                val = rand_bits(32);
                write_reg(reg_addr_e'(DIVOUT0 + i), val);
                read_reg(reg_addr_e'(DIVOUT0 + i), rd);
                check_word($sformatf("DIVOUT%0d", i), rd, val & 32'h0000_00ff);
            end
        end

        // legal random configurations
        for (int k = 0; k < 16; k++) begin
            draw_legal();
            apply_config();
            wait_idle(st);
            check_status(st, status_word(1'b0, 1'b1, 1'b0, 1'b1));
            check_freqs();
            check_tick_pins();
        end

        // zero divin or enabled zero divout
        for (int k = 0; k < 4; k++) begin
            draw_legal();
            if (k % 2 == 0) begin
                cfg_divin = 8'h0;
            end else begin
                cfg_clken[k % NOUT]  = 1'b1;
                cfg_divout[k % NOUT] = 8'h0;
            end
            apply_config();
            wait_idle(st);
            check_status(st, status_word(1'b0, 1'b0, 1'b1, 1'b0));
        end

        // ratio outside the vco range, lock wait times out
        for (int k = 0; k < 3; k++) begin
            draw_legal();
            if (k % 2 == 0)
                cfg_divfb = 16'(VCO_MAX * int'(cfg_divin) + 1 + rand_bits(4));
            else
                cfg_divfb = 16'(1 + rand_bits(8) % (VCO_MIN * int'(cfg_divin) - 1));
            apply_config();
            wait_idle(st);
            check_status(st, status_word(1'b0, 1'b0, 1'b1, 1'b0));
        end

        // bypass, reference straight to the dividers
        for (int k = 0; k < 3; k++) begin
            draw_legal();
            cfg_bypass = 1'b1;
            apply_config();
            wait_idle(st);
            check_status(st, status_word(1'b0, 1'b1, 1'b0, 1'b1));
            check_freqs();
            check_tick_pins();
        end

        // second apply while busy must be dropped
        draw_legal();
        cfg_clken = '1;
        apply_config();
        read_reg(STATUS, rd);
        check_status(rd[3:0], status_word(1'b1, 1'b0, 1'b0, 1'b0));
        write_reg(DIVIN, rand_bits(32));
        write_reg(DIVFB, rand_bits(32));
        write_reg(DIVOUT0, rand_bits(32));
        write_reg(CTRL, 32'h0000_0f03);  // apply plus bypass
        wait_idle(st);
        check_status(st, status_word(1'b0, 1'b1, 1'b0, 1'b1));
        check_freqs();
        read_reg(CTRL, rd);  // first config kept, bypass never taken
        check_word("CTRL", rd, {20'h0, 4'(cfg_clken), 5'h0, cfg_clksel, 1'b0, 1'b0});

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/pll_ctrl_pkg.sv
verilog/pll_wb_regs.sv
verilog/pll_seq.sv
verilog/pll_wrap.sv
verilog/pll_macro_model.sv
verilog/pll_freq_meter.sv
verilog/pll_ctrl_top.sv
dv/pll_ctrl_tb.sv

// File: Bender.yml
package:
  name: pll_ctrl

sources:
  - verilog/pll_ctrl_pkg.sv
  - verilog/pll_wb_regs.sv
  - verilog/pll_seq.sv
  - verilog/pll_wrap.sv
  - verilog/pll_macro_model.sv
  - verilog/pll_freq_meter.sv
  - verilog/pll_ctrl_top.sv
  - target: simulation
    files:
      - dv/pll_ctrl_tb.sv
